// ==== Bender.yml ====
package:
  name: soc_ctrl

sources:
  - logic/wb_bus_pkg.sv
  - logic/net_cfg_pkg.sv
  - logic/wb_addr_decode.sv
  - logic/wb_config_regs.sv
  - logic/gpio_port.sv
  - logic/status_req_timer.sv
  - logic/soc_ctrl_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/soc_ctrl_assert.sv
      - tests/soc_ctrl_tb.sv

// ==== logic/gpio_port.sv ====
`timescale 1ns/1ps

module gpio_port (
	input  logic                    GMII_GTX_CLK_int,
	input  logic                    wb_rst,
	input  wb_bus_pkg::wb_m2s_t     wb_i,
	input  logic [7:0]              sw_i,
	input  logic [5:0]              mux_i,
	input  logic                    rx_packet_loss_i,
	output wb_bus_pkg::wb_s2m_t     wb_o,
	output net_cfg_pkg::gpio_ctrl_t ctrl_o,
	output logic [6:0]              leds_o
);

	localparam int IN_W = 14;

	logic [IN_W-1:0]              in_meta;  // First sync stage
	logic [IN_W-1:0]              in_sync;
	logic [wb_bus_pkg::WB_DW-1:0] gpio_out;
	logic [wb_bus_pkg::WB_DW-1:0] in_word;
	logic                         ack_q;
	logic                         out_sel;  // Word 1 addressed

	assign out_sel = wb_i.adr[2];

	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst) begin
			in_meta <= '0;
			in_sync <= '0;
		end else begin
			in_meta <= {mux_i, sw_i};
			in_sync <= in_meta;
		end
	end

	////////////////////
	// Bus access
	////////////////////

	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst) begin
			ack_q    <= 1'b0;
			gpio_out <= '0;
		end else begin
			ack_q <= wb_i.cyc & wb_i.stb & ~ack_q;
			if (wb_i.cyc & wb_i.stb & wb_i.we & ~ack_q & out_sel) begin
				for (int b = 0; b < wb_bus_pkg::WB_SW; b++)
					if (wb_i.sel[b])
						gpio_out[8*b +: 8] <= wb_i.dat[8*b +: 8];
			end
		end
	end

	// Input word with status bits folded in
	always_comb begin
		in_word                                    = '0;
		in_word[IN_W-1:0]                          = in_sync;
		in_word[net_cfg_pkg::GPIO_OUT_RX_ADDR_RDY]  = ctrl_o.rx_addr_ready;
		in_word[net_cfg_pkg::GPIO_IN_PKT_LOSS]      = rx_packet_loss_i;
		in_word[net_cfg_pkg::GPIO_OUT_TX_BUF_RDY]   = ctrl_o.tx_buf_rdy;
		in_word[net_cfg_pkg::GPIO_OUT_TX_STATUS_EN] = ctrl_o.tx_status_enable;
	end

	assign wb_o.ack = ack_q;
	assign wb_o.dat = out_sel ? gpio_out : in_word;

	// Enables from the switches
	assign ctrl_o.rx_enable        = in_sync[0];
	assign ctrl_o.tx_enable        = in_sync[1];
	assign ctrl_o.rx_addr_ready    = gpio_out[net_cfg_pkg::GPIO_OUT_RX_ADDR_RDY];
	assign ctrl_o.tx_buf_rdy       = gpio_out[net_cfg_pkg::GPIO_OUT_TX_BUF_RDY];
	assign ctrl_o.tx_status_enable = gpio_out[net_cfg_pkg::GPIO_OUT_TX_STATUS_EN];

	assign leds_o = gpio_out[net_cfg_pkg::GPIO_OUT_LED_LSB +: 7];

endmodule

// ==== logic/net_cfg_pkg.sv ====
package net_cfg_pkg;

	localparam int TX_BUF_W = 10;

	// Network settings as seen by the packet engines
	typedef struct packed {
		logic [31:0]         my_ip;
		logic [47:0]         my_mac;
		logic [31:0]         dst_ip;
		logic [47:0]         dst_mac;
		logic [31:0]         rx_addr_offset;
		logic [31:0]         tx_addr_offset;
		logic [TX_BUF_W-1:0] tx_buf_size;
	} net_cfg_t;

	// Word index inside the config bank
	typedef enum logic [3:0] {
		CFG_MY_IP       = 4'd0,
		CFG_MY_MAC_LO   = 4'd1,
		CFG_MY_MAC_HI   = 4'd2, // Upper MAC half in bits 15:0
		CFG_DST_IP      = 4'd3,
		CFG_DST_MAC_LO  = 4'd4,
		CFG_DST_MAC_HI  = 4'd5,
		CFG_RX_OFFSET   = 4'd6,
		CFG_TX_OFFSET   = 4'd7,
		CFG_TX_BUF_SIZE = 4'd8
	} cfg_word_e;

	typedef struct packed {
		logic rx_enable;
		logic tx_enable;
		logic rx_addr_ready;
		logic tx_buf_rdy;
		logic tx_status_enable;
	} gpio_ctrl_t;

	////////////////////
	// Bit positions
	////////////////////

	localparam int GPIO_OUT_LED_LSB      = 16;
	localparam int GPIO_OUT_RX_ADDR_RDY  = 23;
	localparam int GPIO_IN_PKT_LOSS      = 24; // Input word only
	localparam int GPIO_OUT_TX_BUF_RDY   = 25;
	localparam int GPIO_OUT_TX_STATUS_EN = 26;

	localparam int IRQ_UART   = 2;
	localparam int IRQ_SPI    = 6;
	localparam int IRQ_ETH_RX = 8;
	localparam int IRQ_ETH_TX = 9;

endpackage

// ==== logic/soc_ctrl_top.sv ====
`timescale 1ns/1ps

module soc_ctrl_top #(
	parameter logic [15:0] STATUS_DIV = 16'd31249
) (
	input  logic                    GMII_GTX_CLK_int,
	input  logic                    wb_rst,
	input  wb_bus_pkg::wb_m2s_t     wb_i,
	input  logic [7:0]              sw_i,
	input  logic [5:0]              mux_i,
	input  logic                    uart_irq_i,
	input  logic                    spi_irq_i,
	input  logic                    eth_rx_irq_i,
	input  logic                    eth_tx_irq_i,
	input  logic                    rx_packet_loss_i,
	output wb_bus_pkg::wb_s2m_t     wb_o,
	output net_cfg_pkg::net_cfg_t   net_cfg_o,
	output net_cfg_pkg::gpio_ctrl_t ctrl_o,
	output logic [6:0]              leds_o,
	output logic                    tx_fifo_status_req_o,
	output logic [31:0]             irq_o
);

	wb_bus_pkg::wb_m2s_t     cfg_m2s, gpio_m2s;
	wb_bus_pkg::wb_s2m_t     cfg_s2m, gpio_s2m;
	net_cfg_pkg::gpio_ctrl_t gpio_ctrl;

	////////////////////
	// Bus slaves
	////////////////////

	wb_addr_decode u_decode (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.m_i              (wb_i),
		.cfg_s2m_i        (cfg_s2m),
		.gpio_s2m_i       (gpio_s2m),
		.cfg_m2s_o        (cfg_m2s),
		.gpio_m2s_o       (gpio_m2s),
		.m_o              (wb_o)
	);

	wb_config_regs u_cfg (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.wb_i             (cfg_m2s),
		.wb_o             (cfg_s2m),
		.cfg_o            (net_cfg_o)
	);

	gpio_port u_gpio (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.wb_i             (gpio_m2s),
		.sw_i             (sw_i),
		.mux_i            (mux_i),
		.rx_packet_loss_i (rx_packet_loss_i),
		.wb_o             (gpio_s2m),
		.ctrl_o           (gpio_ctrl),
		.leds_o           (leds_o)
	);

	assign ctrl_o = gpio_ctrl;

	status_req_timer #(
		.STATUS_DIV (STATUS_DIV)
	) u_status (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.enable_i         (gpio_ctrl.tx_status_enable),
		.status_req_o     (tx_fifo_status_req_o)
	);

	// Interrupt vector with unused lines tied low
	always_comb begin
		irq_o                          = '0;
		irq_o[net_cfg_pkg::IRQ_UART]   = uart_irq_i;
		irq_o[net_cfg_pkg::IRQ_SPI]    = spi_irq_i;
		irq_o[net_cfg_pkg::IRQ_ETH_RX] = eth_rx_irq_i;
		irq_o[net_cfg_pkg::IRQ_ETH_TX] = eth_tx_irq_i;
	end

endmodule

// ==== logic/status_req_timer.sv ====
`timescale 1ns/1ps

module status_req_timer #(
	parameter logic [15:0] STATUS_DIV = 16'd31249
) (
	input  logic GMII_GTX_CLK_int,
	input  logic wb_rst,
	input  logic enable_i,
	output logic status_req_o
);

	logic [15:0] div_cnt;

	// Toggle period is STATUS_DIV+1 cycles
	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst) begin
			div_cnt      <= '0;
			status_req_o <= 1'b0;
		end else if (enable_i) begin
			if (div_cnt == STATUS_DIV) begin
				status_req_o <= ~status_req_o;
				div_cnt      <= '0;
			end else begin
				div_cnt <= div_cnt + 16'd1;
			end
		end else begin
			// Idle with the line parked low
			div_cnt      <= '0;
			status_req_o <= 1'b0;
		end
	end

endmodule

// ==== logic/wb_addr_decode.sv ====
`timescale 1ns/1ps

module wb_addr_decode (
	input  logic                GMII_GTX_CLK_int,
	input  logic                wb_rst,
	input  wb_bus_pkg::wb_m2s_t m_i,
	input  wb_bus_pkg::wb_s2m_t cfg_s2m_i,
	input  wb_bus_pkg::wb_s2m_t gpio_s2m_i,
	output wb_bus_pkg::wb_m2s_t cfg_m2s_o,
	output wb_bus_pkg::wb_m2s_t gpio_m2s_o,
	output wb_bus_pkg::wb_s2m_t m_o
);

	wb_bus_pkg::wb_slave_e slv_sel;

	// Top address bit splits the map in two halves
	assign slv_sel = wb_bus_pkg::wb_slave_e'(m_i.adr[wb_bus_pkg::WB_AW-1]);

	////////////////////
	// Request side
	////////////////////

	always_comb begin
		cfg_m2s_o  = m_i;
		gpio_m2s_o = m_i;
		// Only the addressed slave sees the strobe
		cfg_m2s_o.stb  = m_i.stb & (slv_sel == wb_bus_pkg::SLV_CFG);
		gpio_m2s_o.stb = m_i.stb & (slv_sel == wb_bus_pkg::SLV_GPIO);
	end

	////////////////////
	// Response side
	////////////////////

	// Address is held until ack so the live select names the acking slave
	always_comb begin
		case (slv_sel)
			wb_bus_pkg::SLV_GPIO: m_o = gpio_s2m_i;
			default:              m_o = cfg_s2m_i;
		endcase
	end

endmodule

// ==== logic/wb_bus_pkg.sv ====
package wb_bus_pkg;

	////////////////////
	// Bus widths
	////////////////////

	localparam int WB_DW = 32; // Data width
	localparam int WB_AW = 8;  // Byte address width
	localparam int WB_SW = WB_DW / 8;

	// Master to slave request held until ack
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [WB_AW-1:0] adr;
		logic [WB_DW-1:0] dat;
		logic [WB_SW-1:0] sel;
	} wb_m2s_t;

	// Slave to master response
	typedef struct packed {
		logic             ack;
		logic [WB_DW-1:0] dat; // Valid while ack is high
	} wb_s2m_t;

	////////////////////
	// Slave map
	////////////////////

	// Picked by the top address bit
	typedef enum logic {
		SLV_CFG  = 1'b0,
		SLV_GPIO = 1'b1
	} wb_slave_e;

endpackage

// ==== logic/wb_config_regs.sv ====
`timescale 1ns/1ps

module wb_config_regs (
	input  logic                  GMII_GTX_CLK_int,
	input  logic                  wb_rst,
	input  wb_bus_pkg::wb_m2s_t   wb_i,
	output wb_bus_pkg::wb_s2m_t   wb_o,
	output net_cfg_pkg::net_cfg_t cfg_o
);

	localparam int IDX_W = 4;
	localparam int WORDS = 2 ** IDX_W;

	logic [wb_bus_pkg::WB_DW-1:0] cfg_words [WORDS];
	logic [IDX_W-1:0]             word_idx;
	logic                         ack_q;
	logic                         wr_en;

	assign word_idx = wb_i.adr[IDX_W+1:2]; // Word aligned
	assign wr_en    = wb_i.cyc & wb_i.stb & wb_i.we & ~ack_q;

	// Single ack per request
	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst)
			ack_q <= 1'b0;
		else
			ack_q <= wb_i.cyc & wb_i.stb & ~ack_q;
	end

	////////////////////
	// Register bank
	////////////////////

	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst) begin
			for (int w = 0; w < WORDS; w++)
				cfg_words[w] <= '0;
		end else if (wr_en) begin
			for (int b = 0; b < wb_bus_pkg::WB_SW; b++)
				if (wb_i.sel[b])
					cfg_words[word_idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
		end
	end

	assign wb_o.ack = ack_q;
	assign wb_o.dat = cfg_words[word_idx]; // Whole word readback

	// Settings view of the bank
	assign cfg_o.my_ip          = cfg_words[net_cfg_pkg::CFG_MY_IP];
	assign cfg_o.my_mac         = {cfg_words[net_cfg_pkg::CFG_MY_MAC_HI][15:0],
		cfg_words[net_cfg_pkg::CFG_MY_MAC_LO]};
	assign cfg_o.dst_ip         = cfg_words[net_cfg_pkg::CFG_DST_IP];
	assign cfg_o.dst_mac        = {cfg_words[net_cfg_pkg::CFG_DST_MAC_HI][15:0],
		cfg_words[net_cfg_pkg::CFG_DST_MAC_LO]};
	assign cfg_o.rx_addr_offset = cfg_words[net_cfg_pkg::CFG_RX_OFFSET];
	assign cfg_o.tx_addr_offset = cfg_words[net_cfg_pkg::CFG_TX_OFFSET];
	assign cfg_o.tx_buf_size    =
		cfg_words[net_cfg_pkg::CFG_TX_BUF_SIZE][net_cfg_pkg::TX_BUF_W-1:0];

endmodule

// ==== soc_ctrl.f ====
logic/wb_bus_pkg.sv
logic/net_cfg_pkg.sv
logic/wb_addr_decode.sv
logic/wb_config_regs.sv
logic/gpio_port.sv
logic/status_req_timer.sv
logic/soc_ctrl_top.sv
tests/tb_clock_gen.sv
tests/soc_ctrl_assert.sv
tests/soc_ctrl_tb.sv

// ==== tests/soc_ctrl_assert.sv ====
`timescale 1ns/1ps

module soc_ctrl_assert #(
	parameter bit          CHECK_TIMER = 1'b0,
	parameter logic [15:0] DIV         = 16'd0
) (
	input logic        clk_i,
	input logic        rst_i,
	input logic        ack_i,
	input logic        cfg_stb_i,
	input logic        gpio_stb_i,
	input logic        enable_i,
	input logic        status_req_i,
	input logic [15:0] div_cnt_i
);

	int fail_cnt = 0; // Failed assertions so far

	generate
		if (CHECK_TIMER) begin : g_timer
			// Toggle only on a full count
			toggle_at_div: assert property (@(posedge clk_i) disable iff (rst_i)
				($past(enable_i) && (status_req_i != $past(status_req_i)))
				|-> ($past(div_cnt_i) == DIV)) else begin
				fail_cnt++;
				$error("Status line toggled before the divider count was reached");
			end
		end else begin : g_bus
			ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
				ack_i |=> !ack_i) else begin
				fail_cnt++;
				$error("Bus ack held high for more than one cycle");
			end
			stb_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
				!(cfg_stb_i && gpio_stb_i)) else begin
				fail_cnt++;
				$error("Both slaves see a strobe in the same cycle");
			end
		end
	endgenerate

endmodule

bind wb_addr_decode soc_ctrl_assert #(.CHECK_TIMER(1'b0)) u_bus_assert (
	.clk_i        (GMII_GTX_CLK_int),
	.rst_i        (wb_rst),
	.ack_i        (m_o.ack),
	.cfg_stb_i    (cfg_m2s_o.stb),
	.gpio_stb_i   (gpio_m2s_o.stb),
	.enable_i     (1'b0),
	.status_req_i (1'b0),
	.div_cnt_i    (16'd0)
);

bind status_req_timer soc_ctrl_assert #(.CHECK_TIMER(1'b1), .DIV(STATUS_DIV)) u_timer_assert (
	.clk_i        (GMII_GTX_CLK_int),
	.rst_i        (wb_rst),
	.ack_i        (1'b0),
	.cfg_stb_i    (1'b0),
	.gpio_stb_i   (1'b0),
	.enable_i     (enable_i),
	.status_req_i (status_req_o),
	.div_cnt_i    (div_cnt)
);

// ==== tests/soc_ctrl_tb.sv ====
`timescale 1ns/1ps

module soc_ctrl_tb;

	localparam logic [15:0] DIV = 16'd5;

	logic                    GMII_GTX_CLK_int;
	logic                    wb_rst;
	wb_bus_pkg::wb_m2s_t     wb_m2s;
	wb_bus_pkg::wb_s2m_t     wb_s2m;
	logic [7:0]              sw;
	logic [5:0]              mux;
	logic                    uart_irq, spi_irq, eth_rx_irq, eth_tx_irq;
	logic                    pkt_loss;
	net_cfg_pkg::net_cfg_t   net_cfg;
	net_cfg_pkg::gpio_ctrl_t ctrl;
	logic [6:0]              leds;
	logic                    status_req;
	logic [31:0]             irq;

	// Trace records
	string       rec_name [$];
	string       rec_op [$];
	logic [31:0] rec_adr [$];
	logic [31:0] rec_dat [$];
	logic [31:0] rec_sel [$];
	logic [31:0] rec_exp [$];
	int          n_rec = 0;

	// Reference model of the written state
	logic [31:0] cfg_model [16];
	logic [31:0] gpio_model;
	logic [15:0] lfsr_q = 16'd39467;

	int          assert_fails;

	tb_clock_gen #(.PERIOD_NS(40), .RST_CYCLES(8)) u_clk (
		.clk_o (GMII_GTX_CLK_int),
		.rst_o (wb_rst)
	);

	soc_ctrl_top #(.STATUS_DIV(DIV)) uut (
		.GMII_GTX_CLK_int     (GMII_GTX_CLK_int),
		.wb_rst               (wb_rst),
		.wb_i                 (wb_m2s),
		.sw_i                 (sw),
		.mux_i                (mux),
		.uart_irq_i           (uart_irq),
		.spi_irq_i            (spi_irq),
		.eth_rx_irq_i         (eth_rx_irq),
		.eth_tx_irq_i         (eth_tx_irq),
		.rx_packet_loss_i     (pkt_loss),
		.wb_o                 (wb_s2m),
		.net_cfg_o            (net_cfg),
		.ctrl_o               (ctrl),
		.leds_o               (leds),
		.tx_fifo_status_req_o (status_req),
		.irq_o                (irq)
	);

	assign assert_fails = uut.u_decode.u_bus_assert.fail_cnt
		+ uut.u_status.u_timer_assert.fail_cnt;

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "Word mismatch");
		end
	endtask

	task automatic check_cfg(input string name, input net_cfg_pkg::net_cfg_t exp,
		input net_cfg_pkg::net_cfg_t act);
		if (act !== exp) begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "Config mismatch");
		end
	endtask

	task automatic check_ctrl(input string name, input net_cfg_pkg::gpio_ctrl_t exp,
		input net_cfg_pkg::gpio_ctrl_t act);
		if (act !== exp) begin
			$display("** Error: %s expected %b actual %b", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "Control mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error: %s expected %b actual %b", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "Bit mismatch");
		end
	endtask

	// Stop at the first failed bound assertion
	always @(negedge GMII_GTX_CLK_int) begin
		if (assert_fails != 0) begin
			$display("A bound assertion on the bus or the status timer failed");
			$display("TEST FAIL");
			$fatal(1, "Assertion failure");
		end
	end

	////////////////////
	// Model
	////////////////////

	function automatic logic [31:0] byte_merge(input logic [31:0] old, input logic [31:0] dat,
		input logic [3:0] sel);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (sel[b])
				res[8*b +: 8] = dat[8*b +: 8];
		return res;
	endfunction

	function automatic net_cfg_pkg::net_cfg_t exp_cfg();
		net_cfg_pkg::net_cfg_t e;
		e.my_ip          = cfg_model[0];
		e.my_mac         = {cfg_model[2][15:0], cfg_model[1]};
		e.dst_ip         = cfg_model[3];
		e.dst_mac        = {cfg_model[5][15:0], cfg_model[4]};
		e.rx_addr_offset = cfg_model[6];
		e.tx_addr_offset = cfg_model[7];
		e.tx_buf_size    = cfg_model[8][9:0];
		return e;
	endfunction

	function automatic net_cfg_pkg::gpio_ctrl_t exp_ctrl();
		net_cfg_pkg::gpio_ctrl_t e;
		e.rx_enable        = sw[0];
		e.tx_enable        = sw[1];
		e.rx_addr_ready    = gpio_model[23];
		e.tx_buf_rdy       = gpio_model[25];
		e.tx_status_enable = gpio_model[26];
		return e;
	endfunction

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bit(output logic b);
		lfsr_q = lfsr_next(lfsr_q);
		b      = lfsr_q[0];
	endtask

	////////////////////
	// Bus and pins
	////////////////////

	// Returns at the falling edge of the ack cycle with the request still held
	task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, output logic [31:0] rdat);
		@(posedge GMII_GTX_CLK_int);
		#2;
		wb_m2s.cyc = 1'b1;
		wb_m2s.stb = 1'b1;
		wb_m2s.we  = we;
		wb_m2s.adr = adr;
		wb_m2s.dat = dat;
		wb_m2s.sel = sel;
		@(negedge GMII_GTX_CLK_int);
		while (!wb_s2m.ack)
			@(negedge GMII_GTX_CLK_int);
		rdat = wb_s2m.dat;
	endtask

	task automatic bus_idle();
		@(posedge GMII_GTX_CLK_int);
		#2;
		wb_m2s = '0;
	endtask

	task automatic do_write(input string name, input logic [7:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		logic [31:0] rdat;
		bus_cycle(1'b1, adr, dat, sel, rdat);
		if (!adr[7])
			cfg_model[adr[5:2]] = byte_merge(cfg_model[adr[5:2]], dat, sel);
		else if (adr[2])
			gpio_model = byte_merge(gpio_model, dat, sel);
		// Visible in the ack cycle
		check_cfg(name, exp_cfg(), net_cfg);
		check_ctrl(name, exp_ctrl(), ctrl);
		check_word(name, {25'd0, gpio_model[22:16]}, {25'd0, leds});
		bus_idle();
		if (!gpio_model[26]) begin
			repeat (3) begin
				@(negedge GMII_GTX_CLK_int);
				check_bit(name, 1'b0, status_req);
			end
		end
	endtask

	task automatic drive_inputs(input string name, input logic [31:0] dat);
		@(posedge GMII_GTX_CLK_int);
		#2;
		sw       = dat[7:0];
		mux      = dat[13:8];
		pkt_loss = dat[24];
		repeat (3) @(negedge GMII_GTX_CLK_int); // Two sync stages plus margin
		check_ctrl(name, exp_ctrl(), ctrl);
	endtask

	task automatic measure_period(input string name, input logic [31:0] exp);
		logic        prev;
		logic [31:0] cnt;
		@(negedge GMII_GTX_CLK_int);
		prev = status_req;
		while (status_req == prev)
			@(negedge GMII_GTX_CLK_int);
		repeat (2) begin
			prev = status_req;
			cnt  = 0;
			do begin
				@(negedge GMII_GTX_CLK_int);
				cnt++;
			end while (status_req == prev);
			check_word(name, exp, cnt);
		end
	endtask

	task automatic irq_patterns(input string name, input int count);
		logic [31:0] exp;
		for (int i = 0; i < count; i++) begin
			@(posedge GMII_GTX_CLK_int);
			#2;
			take_bit(uart_irq);
			take_bit(spi_irq);
			take_bit(eth_rx_irq);
			take_bit(eth_tx_irq);
			@(negedge GMII_GTX_CLK_int);
			exp    = '0;
			exp[2] = uart_irq;
			exp[6] = spi_irq;
			exp[8] = eth_rx_irq;
			exp[9] = eth_tx_irq;
			check_word(name, exp, irq);
		end
	endtask

	task automatic load_trace();
		int          fd;
		string       line, name, op;
		logic [31:0] adr, dat, sel, exp;
		fd = $fopen("tests/soc_ctrl_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file tests/soc_ctrl_trace.txt");
			$display("TEST FAIL");
			$fatal(1, "No trace");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line[0] != "#") begin
				if ($sscanf(line, "%s %s %h %h %h %h", name, op, adr, dat, sel, exp) == 6) begin
					rec_name.push_back(name);
					rec_op.push_back(op);
					rec_adr.push_back(adr);
					rec_dat.push_back(dat);
					rec_sel.push_back(sel);
					rec_exp.push_back(exp);
				end
			end
		end
		$fclose(fd);
		n_rec = rec_name.size();
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		logic [31:0] rdat;
		wb_m2s     = '0;
		sw         = '0;
		mux        = '0;
		pkt_loss   = 1'b0;
		uart_irq   = 1'b0;
		spi_irq    = 1'b0;
		eth_rx_irq = 1'b0;
		eth_tx_irq = 1'b0;
		gpio_model = '0;
		for (int w = 0; w < 16; w++)
			cfg_model[w] = '0;
		load_trace();
		@(negedge wb_rst);
		@(negedge GMII_GTX_CLK_int);
		check_cfg("reset_state", exp_cfg(), net_cfg);
		check_ctrl("reset_state", exp_ctrl(), ctrl);
		check_word("reset_state", 32'd0, {25'd0, leds});
		check_bit("reset_state", 1'b0, status_req);
		for (int r = 0; r < n_rec; r++) begin
			case (rec_op[r])
				"wr": do_write(rec_name[r], rec_adr[r][7:0], rec_dat[r], rec_sel[r][3:0]);
				"rd": begin
					bus_cycle(1'b0, rec_adr[r][7:0], 32'd0, 4'hf, rdat);
					check_word(rec_name[r], rec_exp[r], rdat);
					bus_idle();
				end
				"sw":  drive_inputs(rec_name[r], rec_dat[r]);
				"per": measure_period(rec_name[r], rec_exp[r]);
				"irq": irq_patterns(rec_name[r], rec_dat[r]);
				default: begin
					$display("Unknown operation %s in trace record %0d", rec_op[r], r);
					$display("TEST FAIL");
					$fatal(1, "Bad trace");
				end
			endcase
		end
		repeat (4) @(posedge GMII_GTX_CLK_int);
		if (assert_fails == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("TEST FAIL");
			$fatal(1, "Assertion failure");
		end
	end

	// Watchdog sized from the trace length
	initial begin
		wait (n_rec > 0);
		repeat (n_rec * 200 + 500) @(posedge GMII_GTX_CLK_int);
		$display("The run timed out before all trace records were processed");
		$display("TEST FAIL");
		$fatal(1, "Watchdog expired");
	end

endmodule

// ==== tests/soc_ctrl_trace.txt ====
# name op adr data sel expected (hex), op is wr rd sw per or irq
# sw data holds sw in 7:0, mux in 13:8, packet loss in 24; irq data is the pattern count
reset_cfg0 rd 00 00000000 f 00000000
reset_cfg8 rd 20 00000000 f 00000000
reset_gpio1 rd 84 00000000 f 00000000
my_ip_wr wr 00 c0a80164 f 00000000
my_ip_rd rd 00 00000000 f c0a80164
my_mac_lo_wr wr 04 22334455 f 00000000
my_mac_hi_wr wr 08 ffff0011 3 00000000
my_mac_hi_rd rd 08 00000000 f 00000011
dst_ip_wr wr 0c aabbccdd 5 00000000
dst_ip_rd rd 0c 00000000 f 00bb00dd
dst_mac_hi_wr wr 14 0000a1b2 f 00000000
rx_off_wr wr 18 12345678 c 00000000
rx_off_rd rd 18 00000000 f 12340000
buf_size_wr wr 20 0000fdeb f 00000000
buf_size_rd rd 20 00000000 f 0000fdeb
inputs_set sw 00 01002ad3 0 00000000
gpio_in_rd rd 80 00000000 f 01002ad3
gpio_out_wr wr 84 06d50000 f 00000000
gpio_out_rd rd 84 00000000 f 06d50000
gpio_in_rd2 rd 80 00000000 f 07802ad3
status_period per 00 00000000 0 00000006
status_off wr 84 00d50000 f 00000000
irq_map irq 00 00000010 0 00000000

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS  = 40,
	parameter int RST_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Reset released just after an edge
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		#2 rst_o = 1'b0;
	end

endmodule
